//--- test/usb_testdata.hex
// Each record is code then operand: 1/2 rx byte (2 = last), 3/4 expected tx byte (4 = last)
// 5 idle cycles, 6 configured level, 7 expected status {full, in tog, out tog, configured}
700                                              // after reset
169 185 260 508 700                              // IN while not configured, ignored
601 701
// OUT ep1 DATA0 with five bytes, then IN echoes it, host ACK drains
1E1 185 260 1C3 111 122 133 144 155 12E 2B4 4D2 70B
169 185 260 3C3 311 322 333 344 355 32E 4B4
2D2 503 707
169 185 260 45A                                  // buffer empty, NAK
// DATA1 stored, second OUT gets NAK, echo is still the first packet
1E1 185 260 14B 111 122 133 144 155 12E 2B4 4D2 70D
1E1 185 260 1C3 101 102 103 19E 29E 45A 70D
169 185 260 34B 311 322 333 344 355 32E 4B4
2D2 503 701
1E1 185 260 1C3 101 102 103 19E 29E 4D2 70B    // same OUT now accepted
169 185 260 3C3 301 302 303 39E 49E
2D2 503 707
// Stale toggle is ACKed and dropped
1E1 185 260 1C3 101 102 103 19E 29E 4D2 707
169 185 260 45A
// Bad CRC16, other address, broken PID complement
1E1 185 260 14B 101 102 103 19E 29F 508 707
169 186 220 508
179 185 260 508 707
// Endpoint 2 and SETUP stall, unconfigured IN ignored
169 105 2F9 41E 707
1E1 105 2F9 1C3 100 200 41E
12D 185 260 1C3 100 200 41E 707
600 169 185 260 508 706 601
// Zero-length echo
1E1 185 260 14B 100 200 4D2 70D
169 185 260 34B 300 400
2D2 503 701

//--- usb_bulk_echo_top.f
common/usb_pkg.sv
usb_decode/usb_packet_decode.sv
usb_execute/usb_endpoint_execute.sv
usb_result/usb_response_encode.sv
design/usb_bulk_echo_top.sv
test/usb_tb_clock.sv
test/usb_bulk_echo_tb.sv

//--- Bender.yml
package:
  name: usb_bulk_echo

sources:
  - common/usb_pkg.sv
  - usb_decode/usb_packet_decode.sv
  - usb_execute/usb_endpoint_execute.sv
  - usb_result/usb_response_encode.sv
  - design/usb_bulk_echo_top.sv
  - target: test
    files:
      - test/usb_tb_clock.sv
      - test/usb_bulk_echo_tb.sv

//--- test/usb_bulk_echo_tb.sv
`timescale 1ns/1ns
module usb_bulk_echo_tb;

  logic              clock;
  logic              reset;
  logic              configured;
  logic              rx_valid;
  usb_pkg::rx_byte_t rx;
  logic              tx_ready = 1'b0;
  logic              tx_valid;
  usb_pkg::tx_byte_t tx;
  logic [3:0]        status;

  // Record code in [11:8] and operand in [7:0]
  logic [11:0] recs [512];
  int          rec_count;
  int          cycle_limit = 0;
  int          cycles = 0;
  int          mismatch_count = 0;
  int          fail_count = 0;

  // Transmit bytes still owed by the DUT with the oldest first
  usb_pkg::tx_byte_t expect_q [$];
  logic              held_valid = 1'b0;
  usb_pkg::tx_byte_t held_byte;

  usb_tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  usb_bulk_echo_top u_dut (
    .clock        (clock),
    .reset        (reset),
    .configured_i (configured),
    .rx_valid_i   (rx_valid),
    .rx_i         (rx),
    .tx_ready_i   (tx_ready),
    .tx_valid_o   (tx_valid),
    .tx_o         (tx),
    .status_o     (status)
  );

  task automatic check_tx(input usb_pkg::tx_byte_t got, input usb_pkg::tx_byte_t exp);
    if (got !== exp) begin
      $display("MISMATCH tx_o got data %02h last %0h, expected data %02h last %0h",
               got.data, got.last, exp.data, exp.last);
      mismatch_count++;
    end
  endtask

  task automatic check_status(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("MISMATCH status_o got %01h expected %01h", got, exp);
      mismatch_count++;
    end
  endtask

  // Hold the receive side quiet until every owed byte has been taken
  task automatic drain_expected();
    while (expect_q.size() != 0) begin
      @(posedge clock);
      rx_valid <= 1'b0;
    end
  endtask

  task automatic send_byte(input logic [7:0] data, input logic last);
    drain_expected();
    @(posedge clock);
    rx_valid <= 1'b1;
    rx.data  <= data;
    rx.last  <= last;
  endtask

  task automatic idle_cycles(input int n);
    drain_expected();
    repeat (n) begin
      @(posedge clock);
      rx_valid <= 1'b0;
    end
  endtask

  task automatic set_configured(input logic level);
    drain_expected();
    @(posedge clock);
    rx_valid   <= 1'b0;
    configured <= level;
  endtask

  task automatic sample_status(input logic [3:0] exp);
    drain_expected();
    @(posedge clock);
    rx_valid <= 1'b0;
    @(negedge clock);
    check_status(status, exp);
  endtask

  // Back-pressure on every fourth cycle
  always @(posedge clock) begin
    cycles   <= cycles + 1;
    tx_ready <= (cycles % 4) != 3;
  end

  // Transmit side is sampled on the falling edge
  always @(negedge clock) begin
    if (held_valid && !(tx_valid && tx == held_byte)) begin
      $display("Transmit byte changed or valid dropped while tx_ready_i was low");
      fail_count++;
    end
    held_valid = tx_valid && !tx_ready;
    held_byte  = tx;
    if (!reset && tx_valid && tx_ready) begin
      if (expect_q.size() == 0) begin
        $display("Unexpected transmit byte %02h while no response was due", tx.data);
        fail_count++;
      end else begin
        check_tx(tx, expect_q.pop_front());
      end
    end
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clock);
    end
    fail_count++;
    $display("Run timed out after %0d cycles", cycles);
    if (expect_q.size() != 0) begin
      $display("%0d expected transmit bytes never arrived", expect_q.size());
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [3:0]        code;
    logic [7:0]        arg;
    usb_pkg::tx_byte_t want;
    configured = 1'b0;
    rx_valid   = 1'b0;
    rx         = '0;
    for (int i = 0; i < 512; i++) begin
      recs[i] = '0;
    end
    $readmemh("test/usb_testdata.hex", recs);
    rec_count = 0;
    while (rec_count < 512 && recs[rec_count][11:8] != 4'd0) begin
      rec_count++;
    end
    if (rec_count == 0) begin
      $display("No records were read from the data file");
      fail_count++;
    end
    cycle_limit = 4 * rec_count + 200;
    @(negedge reset);
    for (int i = 0; i < rec_count; i++) begin
      code = recs[i][11:8];
      arg  = recs[i][7:0];
      case (code)
        4'd1, 4'd2: send_byte(arg, code == 4'd2);
        4'd3, 4'd4: begin
          want.data = arg;
          want.last = code == 4'd4;
          expect_q.push_back(want);
        end
        4'd5: idle_cycles(arg);
        4'd6: set_configured(arg[0]);
        4'd7: sample_status(arg[3:0]);
        default: begin
          $display("Record %0d has unknown code %0h", i, code);
          fail_count++;
        end
      endcase
    end
    // Leave room for a stray late response
    idle_cycles(8);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- test/usb_tb_clock.sv
`timescale 1ns/1ns
module usb_tb_clock (
  output logic clock,
  output logic reset
);

  // 40 ns period
  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Reset spans the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- design/usb_bulk_echo_top.sv
`timescale 1ns/1ns
module usb_bulk_echo_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               configured_i,
  input  logic               rx_valid_i,
  input  usb_pkg::rx_byte_t  rx_i,
  input  logic               tx_ready_i,
  output logic               tx_valid_o,
  output usb_pkg::tx_byte_t  tx_o,
  output logic [3:0]         status_o
);

  // Decoded packet events
  logic                token_valid;
  usb_pkg::token_t     token;
  logic                pay_valid;
  usb_pkg::rx_byte_t   pay;
  logic                data_end;
  logic                data_ok;
  logic                data_pid1;
  logic                ack_seen;

  // Response request and buffer read-out
  logic                         resp_start;
  usb_pkg::resp_kind_t          resp_kind;
  logic                         resp_pid1;
  logic                         resp_busy;
  logic [7:0]                   rd_data;
  logic [usb_pkg::buf_bits-1:0] rd_count;
  logic                         rd_next;

  usb_packet_decode u_decode (
    .clock         (clock),
    .reset         (reset),
    .rx_valid_i    (rx_valid_i),
    .rx_i          (rx_i),
    .token_valid_o (token_valid),
    .token_o       (token),
    .pay_valid_o   (pay_valid),
    .pay_o         (pay),
    .data_end_o    (data_end),
    .data_ok_o     (data_ok),
    .data_pid1_o   (data_pid1),
    .ack_seen_o    (ack_seen)
  );

  usb_endpoint_execute u_execute (
    .clock         (clock),
    .reset         (reset),
    .configured_i  (configured_i),
    .token_valid_i (token_valid),
    .token_i       (token),
    .pay_valid_i   (pay_valid),
    .pay_i         (pay),
    .data_end_i    (data_end),
    .data_ok_i     (data_ok),
    .data_pid1_i   (data_pid1),
    .ack_seen_i    (ack_seen),
    .rd_next_i     (rd_next),
    .resp_busy_i   (resp_busy),
    .resp_start_o  (resp_start),
    .resp_kind_o   (resp_kind),
    .resp_pid1_o   (resp_pid1),
    .rd_data_o     (rd_data),
    .rd_count_o    (rd_count),
    .status_o      (status_o)
  );

  usb_response_encode u_response (
    .clock         (clock),
    .reset         (reset),
    .resp_start_i  (resp_start),
    .resp_kind_i   (resp_kind),
    .resp_pid1_i   (resp_pid1),
    .rd_data_i     (rd_data),
    .rd_count_i    (rd_count),
    .tx_ready_i    (tx_ready_i),
    .rd_next_o     (rd_next),
    .resp_busy_o   (resp_busy),
    .tx_valid_o    (tx_valid_o),
    .tx_o          (tx_o)
  );

endmodule

//--- usb_result/usb_response_encode.sv
`timescale 1ns/1ns
module usb_response_encode (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          resp_start_i,
  input  usb_pkg::resp_kind_t           resp_kind_i,
  input  logic                          resp_pid1_i,
  input  logic [7:0]                    rd_data_i,
  input  logic [usb_pkg::buf_bits-1:0]  rd_count_i,
  input  logic                          tx_ready_i,
  output logic                          rd_next_o,
  output logic                          resp_busy_o,
  output logic                          tx_valid_o,
  output usb_pkg::tx_byte_t             tx_o
);

  // State names the byte currently presented on tx_o
  typedef enum logic [2:0] {
    st_idle,
    st_pid,
    st_payload,
    st_crc_lo,
    st_crc_hi
  } state_t;

  state_t                       state_q;
  usb_pkg::resp_kind_t          kind_q;
  logic [usb_pkg::buf_bits-1:0] left_q;
  logic [15:0]                  crc_q;
  logic [15:0]                  crc_next;
  logic [3:0]                   pid;
  logic                         more;

  always_comb begin
    case (resp_kind_i)
      usb_pkg::resp_ack:   pid = usb_pkg::pid_ack;
      usb_pkg::resp_nak:   pid = usb_pkg::pid_nak;
      usb_pkg::resp_stall: pid = usb_pkg::pid_stall;
      default:             pid = resp_pid1_i ? usb_pkg::pid_data1 : usb_pkg::pid_data0;
    endcase
  end

  assign crc_next    = usb_pkg::crc16_step(crc_q, tx_o.data);
  assign more        = left_q != '0;
  assign resp_busy_o = state_q != st_idle;
  // Pull the next stored byte as the current one is taken
  assign rd_next_o   = tx_ready_i && more &&
                       (state_q == st_payload ||
                        (state_q == st_pid && kind_q == usb_pkg::resp_data));

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= st_idle;
      tx_valid_o <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (resp_start_i && resp_kind_i != usb_pkg::resp_none) begin
            kind_q     <= resp_kind_i;
            left_q     <= rd_count_i;
            crc_q      <= usb_pkg::crc16_init;
            tx_o.data  <= {~pid, pid};
            // A handshake is the PID byte alone
            tx_o.last  <= resp_kind_i != usb_pkg::resp_data;
            tx_valid_o <= 1'b1;
            state_q    <= st_pid;
          end
        end
        st_pid: begin
          if (tx_ready_i) begin
            if (kind_q != usb_pkg::resp_data) begin
              tx_valid_o <= 1'b0;
              state_q    <= st_idle;
            end else if (more) begin
              tx_o.data <= rd_data_i;
              tx_o.last <= 1'b0;
              left_q    <= left_q - 1'b1;
              state_q   <= st_payload;
            end else begin
              // Zero-length packet sends the CRC of nothing
              tx_o.data <= ~crc_q[7:0];
              tx_o.last <= 1'b0;
              state_q   <= st_crc_lo;
            end
          end
        end
        st_payload: begin
          if (tx_ready_i) begin
            crc_q <= crc_next;
            if (more) begin
              tx_o.data <= rd_data_i;
              left_q    <= left_q - 1'b1;
            end else begin
              tx_o.data <= ~crc_next[7:0];
              state_q   <= st_crc_lo;
            end
          end
        end
        st_crc_lo: begin
          if (tx_ready_i) begin
            tx_o.data <= ~crc_q[15:8];
            tx_o.last <= 1'b1;
            state_q   <= st_crc_hi;
          end
        end
        st_crc_hi: begin
          if (tx_ready_i) begin
            tx_valid_o <= 1'b0;
            state_q    <= st_idle;
          end
        end
        default: begin
          tx_valid_o <= 1'b0;
          state_q    <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- usb_execute/usb_endpoint_execute.sv
`timescale 1ns/1ns
module usb_endpoint_execute (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          configured_i,
  input  logic                          token_valid_i,
  input  usb_pkg::token_t               token_i,
  input  logic                          pay_valid_i,
  input  usb_pkg::rx_byte_t             pay_i,
  input  logic                          data_end_i,
  input  logic                          data_ok_i,
  input  logic                          data_pid1_i,
  input  logic                          ack_seen_i,
  input  logic                          rd_next_i,
  input  logic                          resp_busy_i,
  output logic                          resp_start_o,
  output usb_pkg::resp_kind_t           resp_kind_o,
  output logic                          resp_pid1_o,
  output logic [7:0]                    rd_data_o,
  output logic [usb_pkg::buf_bits-1:0]  rd_count_o,
  output logic [3:0]                    status_o
);

  logic [7:0] mem_q [usb_pkg::buf_depth];

  logic [usb_pkg::buf_bits-1:0] wr_ptr_q;
  logic [usb_pkg::buf_bits-1:0] rd_ptr_q;
  logic [usb_pkg::buf_bits-1:0] count_q;
  logic [usb_pkg::buf_bits-1:0] wr_count;
  logic                         full_q;
  logic                         out_tog_q;
  logic                         in_tog_q;
  // Last accepted token waiting for its data stage
  logic                         pend_out_q;
  logic                         pend_stall_q;
  // DATA went out and now waits for the host ACK that releases the buffer
  logic                         sent_q;

  logic                         wr_en;
  logic                         tok_ev;
  logic                         end_ev;
  logic                         ack_ev;
  logic                         tok_ep1;
  usb_pkg::resp_kind_t          kind_next;

  // The host stays silent during a response
  assign tok_ev  = token_valid_i && !resp_busy_i && token_i.match && configured_i;
  assign end_ev  = data_end_i && !resp_busy_i;
  assign ack_ev  = ack_seen_i && !resp_busy_i && sent_q;
  assign tok_ep1 = token_i.endp == usb_pkg::echo_ep;

  // A full buffer keeps its packet and oversize bytes are dropped
  assign wr_en    = pay_valid_i && pend_out_q && !full_q && wr_ptr_q < usb_pkg::buf_depth;
  assign wr_count = wr_ptr_q + {{(usb_pkg::buf_bits-1){1'b0}}, wr_en};

  always_comb begin
    kind_next = usb_pkg::resp_none;
    if (tok_ev && token_i.kind == usb_pkg::tok_in) begin
      if (!tok_ep1) begin
        kind_next = usb_pkg::resp_stall;
      end else if (full_q) begin
        kind_next = usb_pkg::resp_data;
      end else begin
        kind_next = usb_pkg::resp_nak;
      end
    end else if (end_ev && data_ok_i) begin
      if (pend_stall_q) begin
        kind_next = usb_pkg::resp_stall;
      end else if (pend_out_q) begin
        // Stale toggle is still ACKed so the host moves on
        kind_next = full_q ? usb_pkg::resp_nak : usb_pkg::resp_ack;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      full_q       <= 1'b0;
      out_tog_q    <= 1'b0;
      in_tog_q     <= 1'b0;
      pend_out_q   <= 1'b0;
      pend_stall_q <= 1'b0;
      sent_q       <= 1'b0;
      resp_start_o <= 1'b0;
    end else begin
      resp_start_o <= kind_next != usb_pkg::resp_none;
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_next_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (tok_ev) begin
        pend_out_q   <= token_i.kind == usb_pkg::tok_out && tok_ep1;
        pend_stall_q <= token_i.kind == usb_pkg::tok_setup ||
                        (token_i.kind == usb_pkg::tok_out && !tok_ep1);
        wr_ptr_q     <= '0;
        if (kind_next == usb_pkg::resp_data) begin
          rd_ptr_q <= '0;
          sent_q   <= 1'b1;
        end
      end
      if (end_ev) begin
        pend_out_q   <= 1'b0;
        pend_stall_q <= 1'b0;
        if (data_ok_i && pend_out_q && !full_q && data_pid1_i == out_tog_q) begin
          full_q    <= 1'b1;
          count_q   <= wr_count;
          out_tog_q <= !out_tog_q;
        end
      end
      if (ack_ev) begin
        full_q   <= 1'b0;
        in_tog_q <= !in_tog_q;
        sent_q   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem_q[wr_ptr_q[usb_pkg::buf_bits-2:0]] <= pay_i.data;
    end
    resp_kind_o <= kind_next;
    resp_pid1_o <= in_tog_q;
  end

  assign rd_data_o  = mem_q[rd_ptr_q[usb_pkg::buf_bits-2:0]];
  assign rd_count_o = count_q;
  assign status_o   = {full_q, in_tog_q, out_tog_q, configured_i};

endmodule

//--- usb_decode/usb_packet_decode.sv
`timescale 1ns/1ns
module usb_packet_decode (
  input  logic               clock,
  input  logic               reset,
  input  logic               rx_valid_i,
  input  usb_pkg::rx_byte_t  rx_i,
  output logic               token_valid_o,
  output usb_pkg::token_t    token_o,
  output logic               pay_valid_o,
  output usb_pkg::rx_byte_t  pay_o,
  output logic               data_end_o,
  output logic               data_ok_o,
  output logic               data_pid1_o,
  output logic               ack_seen_o
);

  // Bytes already seen in this packet up to a ceiling of 3
  logic [1:0]  byte_cnt_q;
  logic [3:0]  pid_q;
  logic        pid_ok_q;
  logic [7:0]  tok_b1_q;
  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;

  // Two-byte delay line that holds back the CRC16 bytes
  logic [7:0]  old_q;
  logic [7:0]  new_q;
  logic [1:0]  fill_q;

  logic                  is_pid;
  logic                  pid_good;
  logic                  is_data;
  logic                  tok_hit;
  usb_pkg::token_kind_t  tok_kind;
  logic [4:0]            crc5_next;
  logic [15:0]           crc16_next;
  logic [6:0]            addr;
  logic [3:0]            endp;

  assign is_pid     = byte_cnt_q == 2'd0;
  assign pid_good   = rx_i.data[7:4] == ~rx_i.data[3:0];
  assign is_data    = pid_ok_q && (pid_q == usb_pkg::pid_data0 || pid_q == usb_pkg::pid_data1);
  assign crc5_next  = usb_pkg::crc5_step(crc5_q, rx_i.data);
  assign crc16_next = usb_pkg::crc16_step(crc16_q, rx_i.data);

  // Endpoint field straddles the two token bytes
  assign addr = tok_b1_q[6:0];
  assign endp = {rx_i.data[2:0], tok_b1_q[7]};

  always_comb begin
    tok_hit  = pid_ok_q;
    tok_kind = usb_pkg::tok_out;
    case (pid_q)
      usb_pkg::pid_out:   tok_kind = usb_pkg::tok_out;
      usb_pkg::pid_in:    tok_kind = usb_pkg::tok_in;
      usb_pkg::pid_setup: tok_kind = usb_pkg::tok_setup;
      // Frame numbers mean nothing to the echo endpoint
      usb_pkg::pid_sof:   tok_hit = 1'b0;
      default:            tok_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      byte_cnt_q    <= 2'd0;
      pid_ok_q      <= 1'b0;
      fill_q        <= 2'd0;
      token_valid_o <= 1'b0;
      pay_valid_o   <= 1'b0;
      data_end_o    <= 1'b0;
      ack_seen_o    <= 1'b0;
    end else begin
      token_valid_o <= 1'b0;
      pay_valid_o   <= 1'b0;
      data_end_o    <= 1'b0;
      ack_seen_o    <= 1'b0;
      if (rx_valid_i) begin
        if (rx_i.last) begin
          byte_cnt_q <= 2'd0;
        end else if (byte_cnt_q != 2'd3) begin
          byte_cnt_q <= byte_cnt_q + 2'd1;
        end
        if (is_pid) begin
          pid_ok_q   <= pid_good;
          fill_q     <= 2'd0;
          ack_seen_o <= rx_i.last && pid_good && rx_i.data[3:0] == usb_pkg::pid_ack;
        end else begin
          token_valid_o <= rx_i.last && byte_cnt_q == 2'd2 && tok_hit &&
                           crc5_next == usb_pkg::crc5_residual;
          if (is_data) begin
            pay_valid_o <= fill_q == 2'd2;
            data_end_o  <= rx_i.last;
            if (fill_q != 2'd2) begin
              fill_q <= fill_q + 2'd1;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_valid_i) begin
      if (is_pid) begin
        pid_q   <= rx_i.data[3:0];
        crc5_q  <= usb_pkg::crc5_init;
        crc16_q <= usb_pkg::crc16_init;
      end else begin
        crc5_q  <= crc5_next;
        crc16_q <= crc16_next;
        old_q   <= new_q;
        new_q   <= rx_i.data;
        if (byte_cnt_q == 2'd1) begin
          tok_b1_q <= rx_i.data;
        end
        // Last payload byte leaves together with the final CRC byte
        pay_o.data <= old_q;
        pay_o.last <= rx_i.last;
      end
      token_o.kind  <= tok_kind;
      token_o.endp  <= endp;
      token_o.match <= addr == usb_pkg::dev_addr;
      data_ok_o     <= byte_cnt_q >= 2'd2 && crc16_next == usb_pkg::crc16_residual;
      data_pid1_o   <= pid_q == usb_pkg::pid_data1;
    end
  end

endmodule

//--- common/usb_pkg.sv
package usb_pkg;

  // Token PIDs
  localparam logic [3:0] pid_out   = 4'b0001;
  localparam logic [3:0] pid_in    = 4'b1001;
  localparam logic [3:0] pid_sof   = 4'b0101;
  localparam logic [3:0] pid_setup = 4'b1101;

  // Data PIDs
  localparam logic [3:0] pid_data0 = 4'b0011;
  localparam logic [3:0] pid_data1 = 4'b1011;

  // Handshake PIDs
  localparam logic [3:0] pid_ack   = 4'b0010;
  localparam logic [3:0] pid_nak   = 4'b1010;
  localparam logic [3:0] pid_stall = 4'b1110;

  localparam logic [6:0] dev_addr = 7'd5;
  localparam logic [3:0] echo_ep  = 4'd1;

  localparam int buf_depth = 64;
  // One extra bit so that a full 64-byte packet can be counted
  localparam int buf_bits  = $clog2(buf_depth) + 1;

  // Both CRCs run bit-reflected and shift the LSB out first
  localparam logic [4:0]  crc5_init      = 5'h1f;
  localparam logic [4:0]  crc5_residual  = 5'h06;
  localparam logic [15:0] crc16_init     = 16'hffff;
  localparam logic [15:0] crc16_residual = 16'hb001;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } rx_byte_t;

  typedef enum logic [1:0] {
    tok_out,
    tok_in,
    tok_setup
  } token_kind_t;

  typedef struct packed {
    token_kind_t kind;
    logic [3:0]  endp;
    logic        match;
  } token_t;

  typedef enum logic [2:0] {
    resp_none,
    resp_ack,
    resp_nak,
    resp_stall,
    resp_data
  } resp_kind_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tx_byte_t;

  // Reflected x^5 + x^2 + 1
  function automatic logic [4:0] crc5_step(logic [4:0] crc, logic [7:0] data);
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 5'h14;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // Reflected x^16 + x^15 + x^2 + 1
  function automatic logic [15:0] crc16_step(logic [15:0] crc, logic [7:0] data);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 16'ha001;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage
